// ==== files.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/data_feeder.sv
rtl/proc_elem.sv
rtl/pe_array.sv
rtl/conv_accel_top.sv
tb/conv_accel_properties.sv
tb/tb_conv_accel.sv

// ==== rtl/conv_accel_top.sv ====
`default_nettype none

`include "conv_defines.svh"

module conv_accel_top (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire conv_pkg::wb_req_t  wb_req,
    output conv_pkg::wb_rsp_t       wb_rsp
);

    //////////////////////////////////////////////////////////////////////
    // Internal buses
    //////////////////////////////////////////////////////////////////////

    // Registered multicast word
    conv_pkg::ybus_word_t                             ybus;
    // All PE accumulators back to the feeder
    logic [`CONV_ROWS*`CONV_COLS*`CONV_ACC_W-1:0]     pe_accs;

    // Host side, decode and readback
    data_feeder i_data_feeder (
        .clk     (clk),
        .rstn    (rstn),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .ybus    (ybus),
        .pe_accs (pe_accs)
    );

    // Compute side
    pe_array #(
        .ROWS (`CONV_ROWS),
        .COLS (`CONV_COLS)
    ) i_pe_array (
        .clk     (clk),
        .rstn    (rstn),
        .ybus    (ybus),
        .pe_accs (pe_accs)
    );

endmodule

`default_nettype wire

// ==== rtl/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Array geometry
//////////////////////////////////////////////////////////////////////
`define CONV_ROWS 2
`define CONV_COLS 2

// Datum width for ifmap, filter and psum
`define CONV_DATA_W 16
// Accumulator width, also the Wishbone data width
`define CONV_ACC_W 32
// Per-kind delivery counter width
`define CONV_CNT_W 16

//////////////////////////////////////////////////////////////////////
// Wishbone word address layout
//////////////////////////////////////////////////////////////////////
`define CONV_ADR_W 7
`define CONV_KIND_LSB 5
`define CONV_STAT_BIT 4
`define CONV_ROW_LSB 2
`define CONV_COL_LSB 0

// Row or column code meaning all
`define CONV_BCAST 2'd3

`endif

// ==== rtl/conv_pkg.sv ====
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Y-bus
    //////////////////////////////////////////////////////////////////////

    // Word kind, also the kind field of the address
    typedef enum logic [1:0] {
        YB_NONE   = 2'b00,
        YB_IFMAP  = 2'b01,
        YB_FILTER = 2'b10,
        YB_PSUM   = 2'b11
    } ybus_kind_t;

    // Multicast word from feeder to every PE
    typedef struct packed {
        logic                    valid;
        ybus_kind_t              kind;
        // Target row, broadcast code hits all rows
        logic [1:0]              row;
        // Target column, same broadcast rule
        logic [1:0]              col;
        logic [`CONV_DATA_W-1:0] dat;
    } ybus_word_t;

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic
    //////////////////////////////////////////////////////////////////////

    // Master side, held until ack
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CONV_ADR_W-1:0] adr;
        logic [`CONV_ACC_W-1:0] dat;
    } wb_req_t;

    // Slave side
    typedef struct packed {
        logic                   ack;
        logic [`CONV_ACC_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/data_feeder.sv ====
`default_nettype none

`include "conv_defines.svh"

module data_feeder (
    input  wire logic                                           clk,
    input  wire logic                                           rstn,
    input  wire conv_pkg::wb_req_t                              wb_req,
    output conv_pkg::wb_rsp_t                                   wb_rsp,
    output conv_pkg::ybus_word_t                                ybus,
    input  wire logic [`CONV_ROWS*`CONV_COLS*`CONV_ACC_W-1:0]   pe_accs
);

    localparam int ACC_W  = `CONV_ACC_W;
    localparam int DATA_W = `CONV_DATA_W;
    localparam int CNT_W  = `CONV_CNT_W;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    conv_pkg::ybus_kind_t adr_kind;
    logic                 adr_stat;
    logic [1:0]           adr_row;
    logic [1:0]           adr_col;
    // Flat PE index, row major
    int unsigned          pe_sel;

    assign adr_kind = conv_pkg::ybus_kind_t'(wb_req.adr[`CONV_KIND_LSB +: 2]);
    assign adr_stat = wb_req.adr[`CONV_STAT_BIT];
    assign adr_row  = wb_req.adr[`CONV_ROW_LSB +: 2];
    assign adr_col  = wb_req.adr[`CONV_COL_LSB +: 2];
    assign pe_sel   = adr_row * `CONV_COLS + adr_col;

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////

    logic ack_q;
    logic new_req;
    logic wr_load;

    // Ack still high means the held strobe was already served
    assign new_req = wb_req.cyc && wb_req.stb && !ack_q;
    // Write of a real kind becomes a Y-bus word
    assign wr_load = new_req && wb_req.we && (adr_kind != conv_pkg::YB_NONE);

    // Y-bus word fields
    logic                 yb_valid;
    conv_pkg::ybus_kind_t yb_kind;
    logic [1:0]           yb_row;
    logic [1:0]           yb_col;
    logic [DATA_W-1:0]    yb_dat;

    // Delivery counters, one per kind, wrapping
    logic [CNT_W-1:0] cnt_ifmap;
    logic [CNT_W-1:0] cnt_filter;
    logic [CNT_W-1:0] cnt_psum;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_q      <= 1'b0;
            yb_valid   <= 1'b0;
            cnt_ifmap  <= '0;
            cnt_filter <= '0;
            cnt_psum   <= '0;
        end else begin
            // Single-cycle ack and word valid
            ack_q    <= new_req;
            yb_valid <= wr_load;
            // Count in step with the word going out
            if (wr_load) begin
                case (adr_kind)
                    conv_pkg::YB_IFMAP:  cnt_ifmap  <= cnt_ifmap + 1'b1;
                    conv_pkg::YB_FILTER: cnt_filter <= cnt_filter + 1'b1;
                    conv_pkg::YB_PSUM:   cnt_psum   <= cnt_psum + 1'b1;
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////

    logic [ACC_W-1:0] rd_mux;
    logic [ACC_W-1:0] rd_dat;

    always_comb begin
        rd_mux = '0;
        if (adr_kind == conv_pkg::YB_NONE) begin
            if (!adr_stat) begin
                // PE accumulator, out of range and broadcast give zero
                if (adr_row < `CONV_ROWS && adr_col < `CONV_COLS) begin
                    rd_mux = pe_accs[pe_sel*ACC_W +: ACC_W];
                end
            end else begin
                // Counter select uses the kind codes
                case (conv_pkg::ybus_kind_t'(adr_col))
                    conv_pkg::YB_IFMAP:  rd_mux = ACC_W'(cnt_ifmap);
                    conv_pkg::YB_FILTER: rd_mux = ACC_W'(cnt_filter);
                    conv_pkg::YB_PSUM:   rd_mux = ACC_W'(cnt_psum);
                    default:             rd_mux = '0;
                endcase
            end
        end
    end

    // Payload of the Y-bus word and the read data
    always_ff @(posedge clk) begin
        if (wr_load) begin
            yb_kind <= adr_kind;
            yb_row  <= adr_row;
            yb_col  <= adr_col;
            // Low half of the bus word is the datum
            yb_dat  <= wb_req.dat[DATA_W-1:0];
        end
        if (new_req && !wb_req.we) begin
            rd_dat <= rd_mux;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat};
    assign ybus   = '{valid: yb_valid, kind: yb_kind, row: yb_row, col: yb_col, dat: yb_dat};

endmodule

`default_nettype wire

// ==== rtl/pe_array.sv ====
`default_nettype none

`include "conv_defines.svh"

module pe_array #(
    parameter int ROWS = `CONV_ROWS,
    parameter int COLS = `CONV_COLS
) (
    input  wire logic                           clk,
    input  wire logic                           rstn,
    input  wire conv_pkg::ybus_word_t           ybus,
    output logic [ROWS*COLS*`CONV_ACC_W-1:0]    pe_accs
);

    localparam int ACC_W = `CONV_ACC_W;
    localparam int N_PE  = ROWS * COLS;

    // One accumulator per PE, row major
    logic [ACC_W-1:0] acc_flat [N_PE];

    //////////////////////////////////////////////////////////////////////
    // PE grid
    //////////////////////////////////////////////////////////////////////

    // Every PE taps the same registered Y-bus
    // One hop to all targets, the match picks who acts
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            proc_elem #(
                .ROW_ID (r),
                .COL_ID (c)
            ) i_pe (
                .clk  (clk),
                .rstn (rstn),
                .ybus (ybus),
                .acc  (acc_flat[r*COLS+c])
            );
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Accumulator readout
    //////////////////////////////////////////////////////////////////////

    // Slot 0 is row 0 column 0 in the low bits
    always_comb begin
        for (int i = 0; i < N_PE; i++) begin
            pe_accs[i*ACC_W +: ACC_W] = acc_flat[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/proc_elem.sv ====
`default_nettype none

`include "conv_defines.svh"

module proc_elem #(
    parameter int ROW_ID = 0,
    parameter int COL_ID = 0
) (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire conv_pkg::ybus_word_t   ybus,
    output logic [`CONV_ACC_W-1:0]      acc
);

    localparam int DATA_W = `CONV_DATA_W;
    localparam int ACC_W  = `CONV_ACC_W;

    //////////////////////////////////////////////////////////////////////
    // Multicast address match
    //////////////////////////////////////////////////////////////////////

    logic row_hit;
    logic col_hit;
    logic match;

    // Own position or the broadcast code
    assign row_hit = (ybus.row == 2'(ROW_ID)) || (ybus.row == `CONV_BCAST);
    assign col_hit = (ybus.col == 2'(COL_ID)) || (ybus.col == `CONV_BCAST);
    assign match   = ybus.valid && row_hit && col_hit;

    //////////////////////////////////////////////////////////////////////
    // Weight and multiply-accumulate
    //////////////////////////////////////////////////////////////////////

    logic signed [DATA_W-1:0]   din;
    logic signed [DATA_W-1:0]   weight;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [ACC_W-1:0]    acc_q;

    // Datum seen as two's complement
    assign din  = ybus.dat;
    // Full signed 16 by 16 product
    assign prod = din * weight;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            weight <= '0;
            acc_q  <= '0;
        end else if (match) begin
            case (ybus.kind)
                // Stationary weight
                conv_pkg::YB_FILTER: weight <= din;
                // Preload, sign extended
                conv_pkg::YB_PSUM:   acc_q  <= ACC_W'(din);
                // Wraps at accumulator width
                conv_pkg::YB_IFMAP:  acc_q  <= acc_q + ACC_W'(prod);
                default: ;
            endcase
        end
    end

    assign acc = acc_q;

endmodule

`default_nettype wire

// ==== tb/conv_accel_properties.sv ====
`default_nettype none

module conv_accel_properties (
    input wire logic                 clk,
    input wire logic                 rstn,
    input wire conv_pkg::wb_req_t    wb_req,
    input wire conv_pkg::wb_rsp_t    wb_rsp,
    input wire conv_pkg::ybus_word_t ybus
);

    // Failed assertions so far, read by the testbench
    int unsigned fail_cnt;

    initial fail_cnt = 0;

    //////////////////////////////////////////////////////////////////////
    // Wishbone handshake
    //////////////////////////////////////////////////////////////////////

    // Ack only answers a strobe seen one cycle earlier
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
        $error("ack raised without a request in the previous cycle");
        fail_cnt++;
    end

    // One ack pulse per request
    a_ack_single: assert property (@(posedge clk) disable iff (!rstn)
        wb_rsp.ack |=> !wb_rsp.ack)
    else begin
        $error("ack held high for two cycles");
        fail_cnt++;
    end

    //////////////////////////////////////////////////////////////////////
    // Y-bus
    //////////////////////////////////////////////////////////////////////

    // Word goes out with the ack of its write
    a_ybus_with_write: assert property (@(posedge clk) disable iff (!rstn)
        ybus.valid |-> (wb_rsp.ack && $past(wb_req.we)))
    else begin
        $error("Y-bus word valid without the ack of a write");
        fail_cnt++;
    end

    // First edge out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> (!wb_rsp.ack && !ybus.valid))
    else begin
        $error("ack or Y-bus valid high in the first cycle after reset");
        fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== tb/tb_conv_accel.sv ====
`default_nettype none

`include "conv_defines.svh"

module tb_conv_accel;

    localparam int MAX_CYCLES = 2000;
    localparam int N_PE       = `CONV_ROWS * `CONV_COLS;

    logic              clk;
    logic              rstn;
    conv_pkg::wb_req_t wb_req;
    conv_pkg::wb_rsp_t wb_rsp;

    conv_accel_top i_conv_accel_top (
        .clk    (clk),
        .rstn   (rstn),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // Handshake and Y-bus checks inside the feeder
    bind data_feeder conv_accel_properties i_props (
        .clk    (clk),
        .rstn   (rstn),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .ybus   (ybus)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock, timeout, LCG
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    int unsigned cycles = 0;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    logic [31:0] seed = 32'he10d;

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    logic signed [15:0] exp_w   [N_PE];
    logic [31:0]        exp_acc [N_PE];
    logic [15:0]        exp_cnt [4];

    function automatic logic [6:0] make_adr(conv_pkg::ybus_kind_t kind, logic stat,
                                            logic [1:0] row, logic [1:0] col);
        return {kind, stat, row, col};
    endfunction

    // Apply the match rule and update weight, psum or accumulator
    function automatic void model_write(conv_pkg::ybus_kind_t kind, logic [1:0] row,
                                        logic [1:0] col, logic [15:0] dat);
        logic signed [31:0] prod;
        int                 i;
        if (kind != conv_pkg::YB_NONE) begin
            exp_cnt[kind] = exp_cnt[kind] + 16'd1;
        end
        for (int r = 0; r < `CONV_ROWS; r++) begin
            for (int c = 0; c < `CONV_COLS; c++) begin
                i = r * `CONV_COLS + c;
                if ((row == r || row == 2'd3) && (col == c || col == 2'd3)) begin
                    case (kind)
                        conv_pkg::YB_FILTER: exp_w[i] = dat;
                        conv_pkg::YB_PSUM:   exp_acc[i] = {{16{dat[15]}}, dat};
                        conv_pkg::YB_IFMAP: begin
                            prod = 32'($signed(dat)) * 32'(exp_w[i]);
                            exp_acc[i] = exp_acc[i] + prod;
                        end
                        default: ;
                    endcase
                end
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////////////////////////

    // Start and end 5 units after a rising edge
    task automatic wb_write(input logic [6:0] adr, input logic [31:0] dat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do begin
            @(posedge clk);
            #5;
        end while (!wb_rsp.ack);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_read(input logic [6:0] adr, output logic [31:0] dat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        do begin
            @(posedge clk);
            #5;
        end while (!wb_rsp.ack);
        dat = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks and test bookkeeping
    //////////////////////////////////////////////////////////////////////

    string       test_name;
    int unsigned errors     = 0;
    int unsigned test_start = 0;
    int unsigned tests_run  = 0;
    int unsigned tests_bad  = 0;

    task automatic read_check(input logic [6:0] adr, input logic [31:0] exp);
        logic [31:0] got;
        wb_read(adr, got);
        assert (got === exp) else begin
            $display("[FAIL] %s adr %h: expected %h, actual %h", test_name, adr, exp, got);
            errors++;
        end
    endtask

    task automatic check_pes();
        for (int i = 0; i < N_PE; i++) begin
            read_check(make_adr(conv_pkg::YB_NONE, 1'b0, 2'(i / `CONV_COLS),
                                2'(i % `CONV_COLS)), exp_acc[i]);
        end
    endtask

    task automatic check_counters();
        for (int k = 1; k < 4; k++) begin
            read_check(make_adr(conv_pkg::YB_NONE, 1'b1, 2'd0, 2'(k)), {16'h0, exp_cnt[k]});
        end
    endtask

    // Upper half random so only the low datum may reach the PEs
    task automatic send(input conv_pkg::ybus_kind_t kind, input logic [1:0] row,
                        input logic [1:0] col, input logic [15:0] dat);
        logic [31:0] word;
        word = next_rand();
        wb_write(make_adr(kind, 1'b0, row, col), {word[31:16], dat});
        model_write(kind, row, col, dat);
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        test_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_start) begin
            tests_bad++;
        end
        $display("%s: %s, %0d errors", test_name,
                 (errors == test_start) ? "passed" : "failed", errors - test_start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    int unsigned prop_fails;
    logic [15:0] dat;

    initial begin
        rstn   = 1'b0;
        wb_req = '0;
        for (int i = 0; i < N_PE; i++) begin
            exp_w[i]   = '0;
            exp_acc[i] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            exp_cnt[k] = '0;
        end
        repeat (10) @(posedge clk);
        #5;
        rstn = 1'b1;
        @(posedge clk);
        #5;

        begin_test("reset_values");
        check_pes();
        check_counters();
        end_test();

        // Each PE alone while its neighbours hold
        begin_test("unicast_mac");
        for (int p = 0; p < N_PE; p++) begin
            dat = 16'(next_rand());
            send(conv_pkg::YB_FILTER, 2'(p / `CONV_COLS), 2'(p % `CONV_COLS), dat);
            repeat (8) begin
                dat = 16'(next_rand());
                send(conv_pkg::YB_IFMAP, 2'(p / `CONV_COLS), 2'(p % `CONV_COLS), dat);
            end
            check_pes();
        end
        end_test();

        begin_test("psum_preload");
        dat = 16'(next_rand());
        send(conv_pkg::YB_PSUM, 2'd1, 2'd0, dat | 16'h8000);
        dat = 16'(next_rand());
        send(conv_pkg::YB_FILTER, 2'd1, 2'd0, dat);
        repeat (4) begin
            dat = 16'(next_rand());
            send(conv_pkg::YB_IFMAP, 2'd1, 2'd0, dat);
        end
        check_pes();
        end_test();

        // Broadcast on row, column, both, and a row outside the array
        begin_test("multicast");
        send(conv_pkg::YB_PSUM, 2'd3, 2'd3, 16'hfff0);
        check_pes();
        send(conv_pkg::YB_FILTER, 2'd3, 2'd3, 16'h0007);
        check_pes();
        send(conv_pkg::YB_IFMAP, 2'd3, 2'd0, 16'h0003);
        check_pes();
        send(conv_pkg::YB_IFMAP, 2'd1, 2'd3, 16'hfffb);
        check_pes();
        dat = 16'(next_rand());
        send(conv_pkg::YB_IFMAP, 2'd3, 2'd3, dat);
        check_pes();
        send(conv_pkg::YB_IFMAP, 2'd2, 2'd3, 16'h0100);
        send(conv_pkg::YB_PSUM, 2'd2, 2'd0, 16'h1234);
        check_pes();
        end_test();

        begin_test("counters_and_decode");
        // Kind none write is dropped and not counted
        wb_write(make_adr(conv_pkg::YB_NONE, 1'b0, 2'd0, 2'd0), 32'h0000_5a5a);
        check_pes();
        check_counters();
        read_check(make_adr(conv_pkg::YB_NONE, 1'b0, 2'd2, 2'd0), 32'h0);
        read_check(make_adr(conv_pkg::YB_NONE, 1'b0, 2'd0, 2'd2), 32'h0);
        read_check(make_adr(conv_pkg::YB_NONE, 1'b0, 2'd3, 2'd3), 32'h0);
        read_check(make_adr(conv_pkg::YB_NONE, 1'b0, 2'd1, 2'd3), 32'h0);
        read_check(make_adr(conv_pkg::YB_NONE, 1'b1, 2'd0, 2'd0), 32'h0);
        read_check(make_adr(conv_pkg::YB_IFMAP, 1'b0, 2'd0, 2'd0), 32'h0);
        read_check(make_adr(conv_pkg::YB_PSUM, 1'b1, 2'd0, 2'd1), 32'h0);
        end_test();

        // Bound assertions watched every cycle so far
        begin_test("bus_properties");
        prop_fails = i_conv_accel_top.i_data_feeder.i_props.fail_cnt;
        errors     = errors + prop_fails;
        end_test();

        $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_bad, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
